//--- bench/tb_typec_link.sv
`timescale 1ns/10ps

module tb_typec_link;

    import typec_pkg::*;

    localparam int ADDR_W = 12;

    logic              clk;
    logic              rst;
    logic              fill_fs;
    logic              fill_fd;
    logic [ADDR_W-1:0] fill_addr;
    logic [ADDR_W-1:0] fill_len;
    logic [7:0]        fill_base;
    logic              tx_fs;
    logic              tx_fd;
    btype_e            tx_btype;
    logic [3:0]        tx_didx;
    logic [7:0]        tx_param;
    logic [7:0]        tx_head;
    logic [ADDR_W-1:0] tx_addr;
    logic [7:0]        tx_len;
    logic              rx_fs;
    logic              rx_fd;
    btype_e            rx_btype;
    logic [3:0]        rx_didx;
    logic [7:0]        rx_bdata;
    logic              rx_dv;
    logic [7:0]        rx_data;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       lfsr = 32'hc4776219;
    // Region written by the last fill, read back by DATA0 packets.
    logic [ADDR_W-1:0] f_addr = '0;
    logic [7:0]        f_len = 8'd0;
    logic [7:0]        f_base = 8'd0;

    typec_link_top #(.ADDR_W(ADDR_W)) uut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            if (lfsr[0]) begin
                lfsr = (lfsr >> 1) ^ 32'h80200003;
            end else begin
                lfsr = lfsr >> 1;
            end
        end
        return v;
    endfunction

    // Bytes on the link for one packet.
    function automatic int pkt_bytes(input btype_e bt, input logic [7:0] len);
        case (bt)
            DLINK, DTYPE, DTEMP: return 3;
            DATA0:               return 4 + int'(len);
            default:             return 2;
        endcase
    endfunction

    task automatic wait_clk();
        @(posedge clk);
        #1;
    endtask

    task automatic check_btype(input string name, input btype_e exp, input btype_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %s actual %s (%0d)", name, exp.name(), act.name(), act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%-10s %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    task automatic do_fill(input string name);
        int cyc;
        cyc = 0;
        fill_addr = f_addr;
        fill_len  = ADDR_W'(f_len);
        fill_base = f_base;
        fill_fs   = 1'b1;
        while (!fill_fd && cyc < 300) begin
            wait_clk();
            cyc++;
        end
        fill_fs = 1'b0;
        if (!fill_fd) begin
            errors++;
            $display("%s: the fill engine never signalled done", name);
        end else begin
            check_byte({name, " fill_fd cycle"}, f_len + 8'd1, 8'(cyc));
        end
    endtask

    // Sends one packet, checks the decode, holds the result, then acknowledges it.
    task automatic run_packet(input string name, input btype_e bt, input logic [3:0] di,
            input logic [7:0] pa, input logic [7:0] hd, input int hold);
        int cyc;
        int ndv;
        cyc = 0;
        ndv = 0;
        tx_btype = bt;
        tx_didx  = di;
        tx_param = pa;
        tx_head  = hd;
        tx_addr  = f_addr;
        tx_len   = f_len;
        tx_fs    = 1'b1;
        while (!tx_fd && cyc < 300) begin
            wait_clk();
            cyc++;
            if (rx_dv) begin
                check_byte({name, " data"}, f_base + 8'(ndv), rx_data);
                ndv++;
            end
        end
        tx_fs = 1'b0;
        if (!tx_fd) begin
            errors++;
            $display("%s: the framer never signalled done", name);
        end else begin
            check_byte({name, " tx_fd cycle"}, 8'(pkt_bytes(bt, f_len) + 1), 8'(cyc));
        end
        cyc = 0;
        while (!rx_fs && cyc < 20) begin
            wait_clk();
            cyc++;
        end
        check_byte({name, " dv count"}, (bt == DATA0) ? f_len : 8'd0, 8'(ndv));
        for (int i = 0; i <= hold; i++) begin
            if (i > 0) begin
                wait_clk();
            end
            if (!rx_fs) begin
                errors++;
                $display("%s: rx_fs low while a result should be pending", name);
            end
            check_btype({name, " btype"}, bt, rx_btype);
            check_byte({name, " didx"}, {4'd0, di}, {4'd0, rx_didx});
            if (bt == DATA0) begin
                check_byte({name, " head"}, hd, rx_bdata);
            end else if (bt == DLINK || bt == DTYPE || bt == DTEMP) begin
                check_byte({name, " param"}, pa, rx_bdata);
            end
        end
        rx_fd = 1'b1;
        wait_clk();
        rx_fd = 1'b0;
        if (rx_fs) begin
            errors++;
            $display("%s: rx_fs still high after the acknowledge", name);
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        check_byte("reset rx_fs", 8'd0, {7'd0, rx_fs});
        check_byte("reset rx_dv", 8'd0, {7'd0, rx_dv});
        check_byte("reset tx_fd", 8'd0, {7'd0, tx_fd});
        check_byte("reset fill_fd", 8'd0, {7'd0, fill_fd});
        check_btype("reset rx_btype", INIT, rx_btype);
        report_test("reset", err0);
    endtask

    task automatic test_control();
        int err0;
        err0 = errors;
        run_packet("ack", ACK, 4'(rand_bits(4)), 8'h00, 8'h00, 0);
        run_packet("nak", NAK, 4'(rand_bits(4)), 8'h00, 8'h00, 0);
        run_packet("stall", STALL, 4'(rand_bits(4)), 8'h00, 8'h00, 0);
        report_test("control", err0);
    endtask

    task automatic test_param();
        int err0;
        err0 = errors;
        run_packet("dlink", DLINK, 4'(rand_bits(4)), 8'(rand_bits(8)), 8'h00, 0);
        run_packet("dtype", DTYPE, 4'(rand_bits(4)), 8'(rand_bits(8)), 8'h00, 0);
        run_packet("dtemp", DTEMP, 4'(rand_bits(4)), 8'(rand_bits(8)), 8'h00, 0);
        report_test("param", err0);
    endtask

    task automatic test_data();
        int err0;
        err0 = errors;
        f_addr = ADDR_W'(rand_bits(ADDR_W));
        f_len  = 8'(rand_bits(5)) + 8'd1;
        f_base = 8'(rand_bits(8));
        do_fill("fill");
        run_packet("data0", DATA0, 4'(rand_bits(4)), 8'h00, 8'(rand_bits(8)), 0);
        report_test("data", err0);
    endtask

    task automatic test_sequence();
        int err0;
        btype_e seq [7];
        err0 = errors;
        seq = '{ACK, NAK, STALL, DLINK, DTYPE, DTEMP, DATA0};
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 7; i++) begin
                run_packet($sformatf("seq %s", seq[i].name()), seq[i], 4'(rand_bits(4)),
                    8'(rand_bits(8)), 8'(rand_bits(8)), 0);
            end
        end
        report_test("sequence", err0);
    endtask

    task automatic test_hold();
        int err0;
        err0 = errors;
        run_packet("hold", DTEMP, 4'(rand_bits(4)), 8'(rand_bits(8)), 8'h00, 12);
        report_test("hold", err0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        fill_fs   = 1'b0;
        fill_addr = '0;
        fill_len  = '0;
        fill_base = 8'd0;
        tx_fs     = 1'b0;
        tx_btype  = INIT;
        tx_didx   = 4'd0;
        tx_param  = 8'd0;
        tx_head   = 8'd0;
        tx_addr   = '0;
        tx_len    = 8'd0;
        rx_fd     = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_clk();
        test_reset();
        test_control();
        test_param();
        test_data();
        test_sequence();
        test_hold();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/typec_link_asserts.sv
`timescale 1ns/10ps

module typec_link_asserts (
    input logic       clk,
    input logic       rst,
    input logic       tx_fs,
    input logic       tx_fd,
    input logic       fill_fd,
    input logic       rx_fs,
    input logic       rx_fd,
    input logic       rx_dv,
    input logic [7:0] com_txd
);

    import typec_pkg::*;

    // Done strobes last a single cycle.
    tx_fd_pulse: assert property (@(posedge clk) disable iff (rst) tx_fd |=> !tx_fd)
        else $error("tx_fd high for more than one cycle");

    fill_fd_pulse: assert property (@(posedge clk) disable iff (rst) fill_fd |=> !fill_fd)
        else $error("fill_fd high for more than one cycle");

    // A pending result is held until it is taken.
    rx_fs_hold: assert property (@(posedge clk) disable iff (rst) rx_fs && !rx_fd |=> rx_fs)
        else $error("rx_fs dropped without rx_fd");

    rx_dv_quiet: assert property (@(posedge clk) disable iff (rst) !(rx_dv && rx_fs))
        else $error("rx_dv high while rx_fs is pending");

    // Without a transmit request the link carries the idle byte.
    link_idle: assert property (@(posedge clk) disable iff (rst) !tx_fs |-> com_txd == IDLE_BYTE)
        else $error("link not idle outside a packet");

endmodule

bind typec_link_top typec_link_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .tx_fs   (tx_fs),
    .tx_fd   (tx_fd),
    .fill_fd (fill_fd),
    .rx_fs   (rx_fs),
    .rx_fd   (rx_fd),
    .rx_dv   (rx_dv),
    .com_txd (com_txd)
);

//--- build.f
src/typec_pkg.sv
src/ram.sv
src/ram_fill.sv
src/typec_tx.sv
src/typecm_rx.sv
src/typec_link_top.sv
bench/typec_link_asserts.sv
bench/tb_typec_link.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_typec_link -f build.f -o sim_typec_link

out=$(./obj_dir/sim_typec_link)
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- src/ram.sv
`timescale 1ns/10ps

module ram #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] ram_txa,
    input  logic [7:0]        ram_txd,
    input  logic              ram_txen,
    input  logic [ADDR_W-1:0] ram_rxa,
    output logic [7:0]        ram_rxd
);

    logic [7:0] mem [0:(1 << ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (ram_txen) begin
            mem[ram_txa] <= ram_txd;
        end
    end

    // The read data follows the address by one cycle.
    always_ff @(posedge clk) begin
        ram_rxd <= mem[ram_rxa];
    end

endmodule

//--- src/ram_fill.sv
`timescale 1ns/10ps

module ram_fill #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs,
    output logic              fd,
    input  logic [ADDR_W-1:0] addr_init,
    input  logic [ADDR_W-1:0] data_len,
    input  logic [7:0]        base,
    output logic [ADDR_W-1:0] ram_txa,
    output logic [7:0]        ram_txd,
    output logic              ram_txen
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_RUN  = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0]        state;
    logic [ADDR_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            cnt      <= '0;
            ram_txen <= 1'b0;
            fd       <= 1'b0;
        end else begin
            fd <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fs) begin
                        cnt <= data_len;
                        if (data_len == '0) begin
                            fd    <= 1'b1;
                            state <= S_WAIT;
                        end else begin
                            ram_txen <= 1'b1;
                            state    <= S_RUN;
                        end
                    end
                end
                S_RUN: begin
                    cnt <= cnt - 1'b1;
                    // Last write of the ramp.
                    if (cnt == ADDR_W'(1)) begin
                        ram_txen <= 1'b0;
                        fd       <= 1'b1;
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (!fs) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address and value counters step together on each write.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && fs) begin
            ram_txa <= addr_init;
            ram_txd <= base;
        end else if (ram_txen) begin
            ram_txa <= ram_txa + 1'b1;
            ram_txd <= ram_txd + 1'b1;
        end
    end

endmodule

//--- src/typec_link_top.sv
`timescale 1ns/10ps

module typec_link_top #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fill_fs,
    output logic              fill_fd,
    input  logic [ADDR_W-1:0] fill_addr,
    input  logic [ADDR_W-1:0] fill_len,
    input  logic [7:0]        fill_base,
    input  logic              tx_fs,
    output logic              tx_fd,
    input  typec_pkg::btype_e tx_btype,
    input  logic [3:0]        tx_didx,
    input  logic [7:0]        tx_param,
    input  logic [7:0]        tx_head,
    input  logic [ADDR_W-1:0] tx_addr,
    input  logic [7:0]        tx_len,
    output logic              rx_fs,
    input  logic              rx_fd,
    output typec_pkg::btype_e rx_btype,
    output logic [3:0]        rx_didx,
    output logic [7:0]        rx_bdata,
    output logic              rx_dv,
    output logic [7:0]        rx_data
);

    logic [ADDR_W-1:0] ram_txa;
    logic [7:0]        ram_txd;
    logic              ram_txen;
    logic [ADDR_W-1:0] ram_rxa;
    logic [7:0]        ram_rxd;
    // Looped back link.
    logic [7:0]        com_txd;

    ram_fill #(.ADDR_W(ADDR_W)) u_ram_fill (
        .clk       (clk),
        .rst       (rst),
        .fs        (fill_fs),
        .fd        (fill_fd),
        .addr_init (fill_addr),
        .data_len  (fill_len),
        .base      (fill_base),
        .ram_txa   (ram_txa),
        .ram_txd   (ram_txd),
        .ram_txen  (ram_txen)
    );

    ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk      (clk),
        .ram_txa  (ram_txa),
        .ram_txd  (ram_txd),
        .ram_txen (ram_txen),
        .ram_rxa  (ram_rxa),
        .ram_rxd  (ram_rxd)
    );

    typec_tx #(.ADDR_W(ADDR_W)) u_typec_tx (
        .clk           (clk),
        .rst           (rst),
        .fs            (tx_fs),
        .fd            (tx_fd),
        .btype         (tx_btype),
        .didx          (tx_didx),
        .param         (tx_param),
        .head          (tx_head),
        .ram_addr_init (tx_addr),
        .data_len      (tx_len),
        .ram_rxa       (ram_rxa),
        .ram_rxd       (ram_rxd),
        .com_txd       (com_txd)
    );

    typecm_rx u_typecm_rx (
        .clk     (clk),
        .rst     (rst),
        .com_rxd (com_txd),
        .fs      (rx_fs),
        .fd      (rx_fd),
        .btype   (rx_btype),
        .didx    (rx_didx),
        .bdata   (rx_bdata),
        .dv      (rx_dv),
        .data    (rx_data)
    );

endmodule

//--- src/typec_pkg.sv
package typec_pkg;

    // Packet type codes carried in the upper half of the header byte.
    typedef enum logic [3:0] {
        INIT  = 4'd0,
        ACK   = 4'd1,
        NAK   = 4'd2,
        STALL = 4'd3,
        DLINK = 4'd8,
        DTYPE = 4'd9,
        DTEMP = 4'd10,
        DATA0 = 4'd13
    } btype_e;

    // Start of packet marker.
    localparam logic [7:0] SYNC_BYTE = 8'hA5;

    // Link value between packets.
    localparam logic [7:0] IDLE_BYTE = 8'h00;

    typedef struct packed {
        btype_e     btype;
        logic [3:0] didx;
    } hdr_fields_s;

    // The header byte seen either as its fields or as the raw link byte.
    typedef union packed {
        hdr_fields_s fields;
        logic [7:0]  raw;
    } hdr_byte_u;

endpackage

//--- src/typec_tx.sv
`timescale 1ns/10ps

module typec_tx #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs,
    output logic              fd,
    input  typec_pkg::btype_e btype,
    input  logic [3:0]        didx,
    input  logic [7:0]        param,
    input  logic [7:0]        head,
    input  logic [ADDR_W-1:0] ram_addr_init,
    input  logic [7:0]        data_len,
    output logic [ADDR_W-1:0] ram_rxa,
    input  logic [7:0]        ram_rxd,
    output logic [7:0]        com_txd
);

    import typec_pkg::*;

    // Each state names the byte loaded into com_txd at its clock edge.
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_HDR   = 3'd1;
    localparam logic [2:0] S_PARAM = 3'd2;
    localparam logic [2:0] S_HEAD  = 3'd3;
    localparam logic [2:0] S_LEN   = 3'd4;
    localparam logic [2:0] S_DATA  = 3'd5;
    localparam logic [2:0] S_END   = 3'd6;
    localparam logic [2:0] S_WAIT  = 3'd7;

    logic [2:0] state;
    logic [7:0] cnt;
    btype_e     btype_q;
    logic [3:0] didx_q;
    logic [7:0] param_q;
    logic [7:0] head_q;
    hdr_byte_u  hdr;

    always_comb begin
        hdr.fields.btype = btype_q;
        hdr.fields.didx  = didx_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= 8'd0;
            fd      <= 1'b0;
            com_txd <= IDLE_BYTE;
        end else begin
            fd <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fs) begin
                        com_txd <= SYNC_BYTE;
                        cnt     <= data_len;
                        state   <= S_HDR;
                    end
                end
                S_HDR: begin
                    com_txd <= hdr.raw;
                    case (btype_q)
                        DLINK, DTYPE, DTEMP: state <= S_PARAM;
                        DATA0:               state <= S_HEAD;
                        default:             state <= S_END;
                    endcase
                end
                S_PARAM: begin
                    com_txd <= param_q;
                    state   <= S_END;
                end
                S_HEAD: begin
                    com_txd <= head_q;
                    state   <= S_LEN;
                end
                S_LEN: begin
                    com_txd <= cnt;
                    if (cnt == 8'd0) begin
                        state <= S_END;
                    end else begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    com_txd <= ram_rxd;
                    cnt     <= cnt - 8'd1;
                    if (cnt == 8'd1) begin
                        state <= S_END;
                    end
                end
                S_END: begin
                    com_txd <= IDLE_BYTE;
                    fd      <= 1'b1;
                    state   <= S_WAIT;
                end
                S_WAIT: begin
                    if (!fs) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request fields are latched at start.
    // The RAM address moves on from the length byte so data follows without a gap.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && fs) begin
            btype_q <= btype;
            didx_q  <= didx;
            param_q <= param;
            head_q  <= head;
            ram_rxa <= ram_addr_init;
        end else if (state == S_LEN || state == S_DATA) begin
            ram_rxa <= ram_rxa + 1'b1;
        end
    end

endmodule

//--- src/typecm_rx.sv
`timescale 1ns/10ps

module typecm_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        com_rxd,
    output logic              fs,
    input  logic              fd,
    output typec_pkg::btype_e btype,
    output logic [3:0]        didx,
    output logic [7:0]        bdata,
    output logic              dv,
    output logic [7:0]        data
);

    import typec_pkg::*;

    // Each state names the byte expected on com_rxd.
    localparam logic [2:0] S_HUNT  = 3'd0;
    localparam logic [2:0] S_HDR   = 3'd1;
    localparam logic [2:0] S_PARAM = 3'd2;
    localparam logic [2:0] S_HEAD  = 3'd3;
    localparam logic [2:0] S_LEN   = 3'd4;
    localparam logic [2:0] S_DATA  = 3'd5;
    localparam logic [2:0] S_HOLD  = 3'd6;

    logic [2:0] state;
    logic [7:0] cnt;
    hdr_byte_u  hdr;

    always_comb begin
        hdr.raw = com_rxd;
    end

    // Payload bytes stream straight from the link.
    assign dv   = (state == S_DATA);
    assign data = com_rxd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_HUNT;
            cnt   <= 8'd0;
            fs    <= 1'b0;
            btype <= INIT;
        end else begin
            case (state)
                S_HUNT: begin
                    if (com_rxd == SYNC_BYTE) begin
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    case (hdr.fields.btype)
                        ACK, NAK, STALL: begin
                            btype <= hdr.fields.btype;
                            fs    <= 1'b1;
                            state <= S_HOLD;
                        end
                        DLINK, DTYPE, DTEMP: begin
                            btype <= hdr.fields.btype;
                            state <= S_PARAM;
                        end
                        DATA0: begin
                            btype <= hdr.fields.btype;
                            state <= S_HEAD;
                        end
                        // An unknown type returns to hunting.
                        default: state <= S_HUNT;
                    endcase
                end
                S_PARAM: begin
                    fs    <= 1'b1;
                    state <= S_HOLD;
                end
                S_HEAD: begin
                    state <= S_LEN;
                end
                S_LEN: begin
                    cnt <= com_rxd;
                    if (com_rxd == 8'd0) begin
                        fs    <= 1'b1;
                        state <= S_HOLD;
                    end else begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    cnt <= cnt - 8'd1;
                    if (cnt == 8'd1) begin
                        fs    <= 1'b1;
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    // No hunting until the result is taken.
                    if (fd) begin
                        fs    <= 1'b0;
                        state <= S_HUNT;
                    end
                end
                default: state <= S_HUNT;
            endcase
        end
    end

    // Head byte of DATA0 shares bdata with the parameter byte.
    always_ff @(posedge clk) begin
        if (state == S_HDR) begin
            didx <= hdr.fields.didx;
        end
        if (state == S_PARAM || state == S_HEAD) begin
            bdata <= com_rxd;
        end
    end

endmodule
